// File: sources.f
+incdir+tb
design/ex_pkg.sv
design/ex_alu.sv
design/ex_arith.sv
design/ex_agu.sv
design/ex_stage.sv
tb/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module ex_stage_tb -f sources.f -o ex_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ex_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected stage outputs for one micro-op, built from the execute rules
function automatic void model_execute(
    input  ex_pkg::ex_uop_t  u,
    input  logic [63:0]      timer,
    input  logic [31:0]      tid,
    input  logic             stall,
    output ex_pkg::ex_mem_t  m,
    output ex_pkg::ex_fwd_t  f,
    output logic             redir,
    output logic [31:0]      target,
    output logic [2:0]       redir_id
);
    logic [31:0]     b;
    logic [31:0]     res;
    logic [31:0]     addr;
    logic            taken;
    logic            is_min;
    longint          prod_s;
    longint unsigned prod_u;

    // second operand as every unit sees it
    b      = u.use_imm ? u.imm : u.opnd2;
    prod_s = longint'($signed(u.opnd1)) * longint'($signed(b));
    prod_u = {32'h0, u.opnd1} * {32'h0, b};
    is_min = (u.opnd1 == 32'h8000_0000) && (b == 32'hffff_ffff);

    case (u.aluop)
        ex_pkg::OP_BEQ:  taken = (u.opnd1 == b);
        ex_pkg::OP_BNE:  taken = (u.opnd1 != b);
        ex_pkg::OP_BLT:  taken = (int'(u.opnd1) < int'(b));
        ex_pkg::OP_BGE:  taken = (int'(u.opnd1) >= int'(b));
        ex_pkg::OP_BLTU: taken = (u.opnd1 < b);
        ex_pkg::OP_BGEU: taken = (u.opnd1 >= b);
        ex_pkg::OP_B,
        ex_pkg::OP_JIRL: taken = 1'b1;
        default:         taken = 1'b0;
    endcase
    target = (u.aluop == ex_pkg::OP_JIRL) ? u.opnd1 + u.imm : u.pc + u.imm;

    case (u.aluop)
        ex_pkg::OP_AND:     res = u.opnd1 & b;
        ex_pkg::OP_OR:      res = u.opnd1 | b;
        ex_pkg::OP_XOR:     res = u.opnd1 ^ b;
        ex_pkg::OP_NOR:     res = ~(u.opnd1 | b);
        ex_pkg::OP_SLL:     res = u.opnd1 << b[4:0];
        ex_pkg::OP_SRL:     res = u.opnd1 >> b[4:0];
        ex_pkg::OP_SRA:     res = 32'(int'(u.opnd1) >>> b[4:0]);
        ex_pkg::OP_JIRL:    res = u.pc + 32'd4;
        ex_pkg::OP_ADD:     res = u.opnd1 + b;
        ex_pkg::OP_SUB:     res = u.opnd1 - b;
        ex_pkg::OP_MUL:     res = prod_s[31:0];
        ex_pkg::OP_MULH:    res = prod_s[63:32];
        ex_pkg::OP_MULHU:   res = prod_u[63:32];
        // zero divisor returns the dividend, overflow keeps the minimum
        ex_pkg::OP_DIV:     res = (b == 0 || is_min) ? u.opnd1 : 32'(int'(u.opnd1) / int'(b));
        ex_pkg::OP_DIVU:    res = (b == 0) ? u.opnd1 : u.opnd1 / b;
        ex_pkg::OP_MOD:     res = (b == 0) ? u.opnd1 : (is_min ? 32'd0
                                                           : 32'(int'(u.opnd1) % int'(b)));
        ex_pkg::OP_MODU:    res = (b == 0) ? u.opnd1 : u.opnd1 % b;
        ex_pkg::OP_SLT:     res = (int'(u.opnd1) < int'(b)) ? 32'd1 : 32'd0;
        ex_pkg::OP_SLTU:    res = (u.opnd1 < b) ? 32'd1 : 32'd0;
        ex_pkg::OP_LUI:     res = b;
        ex_pkg::OP_PCADD:   res = u.pc + b;
        ex_pkg::OP_RDCNTID: res = tid;
        ex_pkg::OP_RDCNTVL: res = timer[31:0];
        ex_pkg::OP_RDCNTVH: res = timer[63:32];
        ex_pkg::OP_CSRRD,
        ex_pkg::OP_CSRWR,
        ex_pkg::OP_CSRXCHG: res = u.csr_rdata;
        default:            res = 32'd0;
    endcase
    if (u.alusel == ex_pkg::RES_NONE) begin
        res = 32'd0;
    end

    addr            = u.opnd1 + u.imm;
    m               = '0;
    m.valid         = u.valid;
    m.pc            = u.pc;
    m.wreg          = u.wreg;
    m.waddr         = u.waddr;
    m.wdata         = res;
    m.mem_load      = u.mem_load;
    m.mem_store     = u.mem_store;
    m.mem_size      = u.mem_size;
    m.mem_addr      = addr;
    m.store_data    = b;
    m.csr_we        = u.csr_we;
    m.csr_addr      = u.csr_addr;
    m.csr_wdata     = (u.aluop == ex_pkg::OP_CSRXCHG) ? ((u.opnd1 & b) | (u.csr_rdata & ~b))
                                                      : u.opnd1;
    m.excp_ale      = (u.mem_load || u.mem_store)
                      && ((u.mem_size == ex_pkg::SIZE_HALF && addr[0])
                          || (u.mem_size == ex_pkg::SIZE_WORD && addr[1:0] != 2'b00));
    m.last_in_block = taken;
    m.ftq_id        = u.ftq_id;

    f.valid  = u.valid && u.wreg && !u.mem_load;
    f.waddr  = u.waddr;
    f.wdata  = res;

    redir    = u.valid && taken && !u.predicted_taken && !stall;
    redir_id = redir ? u.ftq_id : 3'd0;
endfunction

`endif

// File: tb/ex_stage_tb.sv
`default_nettype none

`include "ex_ref_model.svh"

module ex_stage_tb;

    localparam int NUM_OPS        = 2000;
    // ops plus headroom for reset and drain cycles
    localparam int TIMEOUT_CYCLES = NUM_OPS + (NUM_OPS * 3) / 10;

    logic            clk;
    logic            rst;
    ex_pkg::ex_uop_t uop;
    logic [63:0]     timer;
    logic [31:0]     tid;
    logic            stall;
    logic            flush;
    ex_pkg::ex_mem_t ex_mem;
    ex_pkg::ex_fwd_t fwd;
    logic            redirect;
    logic [31:0]     redirect_target;
    logic [2:0]      redirect_ftq_id;

    ex_pkg::ex_mem_t exp_ex_mem;
    ex_pkg::ex_mem_t next_ex_mem;
    ex_pkg::ex_fwd_t exp_fwd;
    logic            exp_redirect;
    logic [31:0]     exp_target;
    logic [2:0]      exp_ftq_id;
    int              ex_mem_errors = 0;
    int              fwd_errors = 0;
    int              redirect_errors = 0;
    int              cycles = 0;

    ex_stage dut0 (
        .clk               (clk),
        .rst               (rst),
        .uop_i             (uop),
        .timer_64_i        (timer),
        .tid_i             (tid),
        .stall_i           (stall),
        .flush_i           (flush),
        .ex_mem_o          (ex_mem),
        .fwd_o             (fwd),
        .redirect_o        (redirect),
        .redirect_target_o (redirect_target),
        .redirect_ftq_id_o (redirect_ftq_id)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // result source that decode would attach to each opcode
    function automatic ex_pkg::res_sel_e sel_for_op(input ex_pkg::alu_op_e op);
        case (op)
            ex_pkg::OP_AND, ex_pkg::OP_OR, ex_pkg::OP_XOR, ex_pkg::OP_NOR:
                return ex_pkg::RES_LOGIC;
            ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA:
                return ex_pkg::RES_SHIFT;
            ex_pkg::OP_LUI, ex_pkg::OP_PCADD:
                return ex_pkg::RES_MOVE;
            ex_pkg::OP_JIRL:
                return ex_pkg::RES_JUMP;
            ex_pkg::OP_CSRRD, ex_pkg::OP_CSRWR, ex_pkg::OP_CSRXCHG,
            ex_pkg::OP_RDCNTVL, ex_pkg::OP_RDCNTVH, ex_pkg::OP_RDCNTID:
                return ex_pkg::RES_CSR;
            ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_MUL, ex_pkg::OP_MULH,
            ex_pkg::OP_MULHU, ex_pkg::OP_DIV, ex_pkg::OP_DIVU, ex_pkg::OP_MOD,
            ex_pkg::OP_MODU, ex_pkg::OP_SLT, ex_pkg::OP_SLTU:
                return ex_pkg::RES_ARITH;
            default:
                return ex_pkg::RES_NONE;
        endcase
    endfunction

    // corner values often enough to hit div by zero, overflow and equal compares
    function automatic logic [31:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'($urandom_range(0, 15));
            default: return $urandom;
        endcase
    endfunction

    task automatic drive_random_uop();
        ex_pkg::ex_uop_t u;
        int unsigned     kind;
        u                 = '0;
        u.valid           = ($urandom_range(0, 9) != 0);
        u.pc              = $urandom & 32'hffff_fffc;
        u.aluop           = ex_pkg::alu_op_e'(6'($urandom_range(0, 33)));
        u.alusel          = sel_for_op(u.aluop);
        u.opnd1           = pick_operand();
        u.opnd2           = pick_operand();
        u.imm             = pick_operand();
        u.use_imm         = ($urandom_range(0, 1) == 1);
        u.wreg            = ($urandom_range(0, 3) != 0);
        u.waddr           = 5'($urandom);
        kind              = $urandom_range(0, 3);
        u.mem_load        = (kind == 1);
        u.mem_store       = (kind == 2);
        u.mem_size        = ex_pkg::mem_size_e'(2'($urandom_range(0, 2)));
        u.csr_we          = (u.alusel == ex_pkg::RES_CSR) && ($urandom_range(0, 1) == 1);
        u.csr_addr        = 14'($urandom);
        u.csr_rdata       = $urandom;
        u.predicted_taken = ($urandom_range(0, 1) == 1);
        u.ftq_id          = 3'($urandom);
        uop   <= u;
        timer <= {$urandom, $urandom};
        tid   <= $urandom;
        stall <= ($urandom_range(0, 9) == 0);
        flush <= ($urandom_range(0, 99) < 3);
    endtask

    task automatic drive_idle();
        uop   <= '0;
        stall <= 1'b0;
        flush <= 1'b0;
    endtask

    task automatic check_ex_mem(input ex_pkg::ex_mem_t got, input ex_pkg::ex_mem_t exp);
        if (got !== exp) begin
            ex_mem_errors++;
            $display("error @%0t: ex_mem_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_fwd(input ex_pkg::ex_fwd_t got, input ex_pkg::ex_fwd_t exp);
        if (got.valid !== exp.valid
            || (exp.valid && (got.waddr !== exp.waddr || got.wdata !== exp.wdata))) begin
            fwd_errors++;
            $display("error @%0t: fwd_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_redirect(input logic got, input logic [31:0] got_target,
                                  input logic [2:0] got_id, input logic exp,
                                  input logic [31:0] exp_tgt, input logic [2:0] exp_id);
        if (got !== exp || got_id !== exp_id || (exp && got_target !== exp_tgt)) begin
            redirect_errors++;
            $display("error @%0t: redirect got %b/%h/%0d expected %b/%h/%0d", $time,
                     got, got_target, got_id, exp, exp_tgt, exp_id);
        end
    endtask

    initial begin
        void'($urandom(32'h24f9_1a03));
        rst        = 1'b1;
        uop        = '0;
        timer      = '0;
        tid        = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        exp_ex_mem = '0;
        for (int i = 0; i <= NUM_OPS + 1; i++) begin
            @(posedge clk);
            if (i == 1) begin
                rst <= 1'b0;
            end
            if (i >= 1 && i <= NUM_OPS) begin
                drive_random_uop();
            end else begin
                drive_idle();
            end
            // outputs are settled half a cycle after the drive edge
            @(negedge clk);
            check_ex_mem(ex_mem, exp_ex_mem);
            model_execute(uop, timer, tid, stall, next_ex_mem, exp_fwd,
                          exp_redirect, exp_target, exp_ftq_id);
            check_fwd(fwd, exp_fwd);
            check_redirect(redirect, redirect_target, redirect_ftq_id,
                           exp_redirect, exp_target, exp_ftq_id);
            if (rst || flush) begin
                exp_ex_mem = '0;
            end else if (!stall) begin
                exp_ex_mem = next_ex_mem;
            end
        end
        $display("errors: ex_mem %0d, fwd %0d, redirect %0d",
                 ex_mem_errors, fwd_errors, redirect_errors);
        if (ex_mem_errors + fwd_errors + redirect_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/ex_stage.sv
`default_nettype none

module ex_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  ex_pkg::ex_uop_t                uop_i,
    input  logic [63:0]                    timer_64_i,
    input  logic [ex_pkg::XLEN-1:0]        tid_i,
    input  logic                           stall_i,
    input  logic                           flush_i,
    output ex_pkg::ex_mem_t                ex_mem_o,
    output ex_pkg::ex_fwd_t                fwd_o,
    output logic                           redirect_o,
    output logic [ex_pkg::XLEN-1:0]        redirect_target_o,
    output logic [ex_pkg::FTQ_IDW-1:0]     redirect_ftq_id_o
);

    logic [ex_pkg::XLEN-1:0] opnd2_sel;
    ex_pkg::ex_uop_t         uop_sel;
    logic [ex_pkg::XLEN-1:0] logic_out;
    logic [ex_pkg::XLEN-1:0] shift_out;
    logic [ex_pkg::XLEN-1:0] arith_out;
    logic [ex_pkg::XLEN-1:0] move_out;
    logic                    branch_taken;
    logic [ex_pkg::XLEN-1:0] branch_target;
    logic [ex_pkg::XLEN-1:0] mem_addr;
    logic                    excp_ale;
    logic [ex_pkg::XLEN-1:0] csr_wdata;
    logic [ex_pkg::XLEN-1:0] csr_read_data;
    logic [ex_pkg::XLEN-1:0] wdata;
    ex_pkg::ex_mem_t         ex_mem_d;

    assign opnd2_sel = uop_i.use_imm ? uop_i.imm : uop_i.opnd2;

    // agu sees the same second operand as the other units
    always_comb begin
        uop_sel       = uop_i;
        uop_sel.opnd2 = opnd2_sel;
    end

    ex_alu u_alu (
        .aluop_i         (uop_i.aluop),
        .pc_i            (uop_i.pc),
        .opnd1_i         (uop_i.opnd1),
        .opnd2_i         (opnd2_sel),
        .imm_i           (uop_i.imm),
        .logic_out_o     (logic_out),
        .shift_out_o     (shift_out),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    ex_arith u_arith (
        .aluop_i     (uop_i.aluop),
        .opnd1_i     (uop_i.opnd1),
        .opnd2_i     (opnd2_sel),
        .arith_out_o (arith_out)
    );

    ex_agu u_agu (
        .uop_i           (uop_sel),
        .timer_64_i      (timer_64_i),
        .tid_i           (tid_i),
        .mem_addr_o      (mem_addr),
        .excp_ale_o      (excp_ale),
        .csr_wdata_o     (csr_wdata),
        .csr_read_data_o (csr_read_data)
    );

    always_comb begin
        case (uop_i.aluop)
            ex_pkg::OP_LUI:   move_out = opnd2_sel;
            ex_pkg::OP_PCADD: move_out = uop_i.pc + opnd2_sel;
            default:          move_out = '0;
        endcase
    end

    always_comb begin
        case (uop_i.alusel)
            ex_pkg::RES_LOGIC: wdata = logic_out;
            ex_pkg::RES_SHIFT: wdata = shift_out;
            ex_pkg::RES_MOVE:  wdata = move_out;
            ex_pkg::RES_ARITH: wdata = arith_out;
            // link address
            ex_pkg::RES_JUMP:  wdata = uop_i.pc + 32'd4;
            ex_pkg::RES_CSR:   wdata = csr_read_data;
            default:           wdata = '0;
        endcase
    end

    // mispredict only when taken but fetch went sequential
    assign redirect_o        = uop_i.valid & branch_taken & ~uop_i.predicted_taken & ~stall_i;
    assign redirect_target_o = branch_target;
    assign redirect_ftq_id_o = redirect_o ? uop_i.ftq_id : '0;

    // loads forward from the memory stage instead
    assign fwd_o.valid = uop_i.valid & uop_i.wreg & ~uop_i.mem_load;
    assign fwd_o.waddr = uop_i.waddr;
    assign fwd_o.wdata = wdata;

    always_comb begin
        ex_mem_d.valid         = uop_i.valid;
        ex_mem_d.pc            = uop_i.pc;
        ex_mem_d.wreg          = uop_i.wreg;
        ex_mem_d.waddr         = uop_i.waddr;
        ex_mem_d.wdata         = wdata;
        ex_mem_d.mem_load      = uop_i.mem_load;
        ex_mem_d.mem_store     = uop_i.mem_store;
        ex_mem_d.mem_size      = uop_i.mem_size;
        ex_mem_d.mem_addr      = mem_addr;
        ex_mem_d.store_data    = opnd2_sel;
        ex_mem_d.csr_we        = uop_i.csr_we;
        ex_mem_d.csr_addr      = uop_i.csr_addr;
        ex_mem_d.csr_wdata     = csr_wdata;
        ex_mem_d.excp_ale      = excp_ale;
        // a taken branch ends the fetch block
        ex_mem_d.last_in_block = branch_taken;
        ex_mem_d.ftq_id        = uop_i.ftq_id;
    end

    // flush wins over stall
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            ex_mem_o <= '0;
        end else if (!stall_i) begin
            ex_mem_o <= ex_mem_d;
        end
    end

    a_flush_clears: assert property (@(posedge clk) flush_i |=> !ex_mem_o.valid)
        else $error("ex_mem_o valid after flush");

    a_redirect_valid: assert property (@(posedge clk) disable iff (rst)
        redirect_o |-> uop_i.valid)
        else $error("redirect without a valid micro-op");

endmodule

`default_nettype wire

// File: design/ex_agu.sv
`default_nettype none

module ex_agu (
    input  ex_pkg::ex_uop_t         uop_i,
    input  logic [63:0]             timer_64_i,
    input  logic [ex_pkg::XLEN-1:0] tid_i,
    output logic [ex_pkg::XLEN-1:0] mem_addr_o,
    output logic                    excp_ale_o,
    output logic [ex_pkg::XLEN-1:0] csr_wdata_o,
    output logic [ex_pkg::XLEN-1:0] csr_read_data_o
);

    logic access_mem;
    logic misaligned;

    // base plus offset
    assign mem_addr_o = uop_i.opnd1 + uop_i.imm;

    assign access_mem = uop_i.mem_load | uop_i.mem_store;

    always_comb begin
        case (uop_i.mem_size)
            ex_pkg::SIZE_HALF: misaligned = mem_addr_o[0];
            ex_pkg::SIZE_WORD: misaligned = |mem_addr_o[1:0];
            // byte access never faults
            default:           misaligned = 1'b0;
        endcase
    end

    assign excp_ale_o = access_mem & misaligned;

    // xchg writes only the bits selected by the mask in opnd2
    always_comb begin
        if (uop_i.aluop == ex_pkg::OP_CSRXCHG) begin
            csr_wdata_o = (uop_i.opnd1 & uop_i.opnd2) | (uop_i.csr_rdata & ~uop_i.opnd2);
        end else begin
            csr_wdata_o = uop_i.opnd1;
        end
    end

    // counter reads bypass the csr file
    always_comb begin
        case (uop_i.aluop)
            ex_pkg::OP_RDCNTID: csr_read_data_o = tid_i;
            ex_pkg::OP_RDCNTVL: csr_read_data_o = timer_64_i[31:0];
            ex_pkg::OP_RDCNTVH: csr_read_data_o = timer_64_i[63:32];
            default:            csr_read_data_o = uop_i.csr_rdata;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_arith.sv
`default_nettype none

module ex_arith (
    input  ex_pkg::alu_op_e         aluop_i,
    input  logic [ex_pkg::XLEN-1:0] opnd1_i,
    input  logic [ex_pkg::XLEN-1:0] opnd2_i,
    output logic [ex_pkg::XLEN-1:0] arith_out_o
);

    logic signed [2*ex_pkg::XLEN-1:0] prod_s;
    logic [2*ex_pkg::XLEN-1:0]        prod_u;
    logic                             div_zero;
    logic                             div_ovf;
    logic [ex_pkg::XLEN-1:0]          quot_s;
    logic [ex_pkg::XLEN-1:0]          rem_s;
    logic [ex_pkg::XLEN-1:0]          quot_u;
    logic [ex_pkg::XLEN-1:0]          rem_u;

    assign prod_s = $signed(opnd1_i) * $signed(opnd2_i);
    assign prod_u = {{ex_pkg::XLEN{1'b0}}, opnd1_i} * {{ex_pkg::XLEN{1'b0}}, opnd2_i};

    assign div_zero = (opnd2_i == '0);
    // most negative value divided by minus one
    assign div_ovf  = (opnd1_i == {1'b1, {(ex_pkg::XLEN-1){1'b0}}}) && (&opnd2_i);

    always_comb begin
        if (div_zero) begin
            quot_s = opnd1_i;
            rem_s  = opnd1_i;
        end else if (div_ovf) begin
            quot_s = opnd1_i;
            rem_s  = '0;
        end else begin
            quot_s = $signed(opnd1_i) / $signed(opnd2_i);
            rem_s  = $signed(opnd1_i) % $signed(opnd2_i);
        end
    end

    always_comb begin
        if (div_zero) begin
            quot_u = opnd1_i;
            rem_u  = opnd1_i;
        end else begin
            quot_u = opnd1_i / opnd2_i;
            rem_u  = opnd1_i % opnd2_i;
        end
    end

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_ADD:   arith_out_o = opnd1_i + opnd2_i;
            ex_pkg::OP_SUB:   arith_out_o = opnd1_i - opnd2_i;
            ex_pkg::OP_MUL:   arith_out_o = prod_s[ex_pkg::XLEN-1:0];
            ex_pkg::OP_MULH:  arith_out_o = prod_s[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            ex_pkg::OP_MULHU: arith_out_o = prod_u[2*ex_pkg::XLEN-1:ex_pkg::XLEN];
            ex_pkg::OP_DIV:   arith_out_o = quot_s;
            ex_pkg::OP_DIVU:  arith_out_o = quot_u;
            ex_pkg::OP_MOD:   arith_out_o = rem_s;
            ex_pkg::OP_MODU:  arith_out_o = rem_u;
            ex_pkg::OP_SLT:   arith_out_o = {31'b0, $signed(opnd1_i) < $signed(opnd2_i)};
            ex_pkg::OP_SLTU:  arith_out_o = {31'b0, opnd1_i < opnd2_i};
            default:          arith_out_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_alu.sv
`default_nettype none

module ex_alu (
    input  ex_pkg::alu_op_e              aluop_i,
    input  logic [ex_pkg::XLEN-1:0]      pc_i,
    input  logic [ex_pkg::XLEN-1:0]      opnd1_i,
    input  logic [ex_pkg::XLEN-1:0]      opnd2_i,
    input  logic [ex_pkg::XLEN-1:0]      imm_i,
    output logic [ex_pkg::XLEN-1:0]      logic_out_o,
    output logic [ex_pkg::XLEN-1:0]      shift_out_o,
    output logic                         branch_taken_o,
    output logic [ex_pkg::XLEN-1:0]      branch_target_o
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    // only the low five bits count for a 32-bit shift
    assign shamt = opnd2_i[4:0];

    assign eq   = (opnd1_i == opnd2_i);
    assign lt_s = ($signed(opnd1_i) < $signed(opnd2_i));
    assign lt_u = (opnd1_i < opnd2_i);

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_AND: logic_out_o = opnd1_i & opnd2_i;
            ex_pkg::OP_OR:  logic_out_o = opnd1_i | opnd2_i;
            ex_pkg::OP_XOR: logic_out_o = opnd1_i ^ opnd2_i;
            ex_pkg::OP_NOR: logic_out_o = ~(opnd1_i | opnd2_i);
            default:        logic_out_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_SLL: shift_out_o = opnd1_i << shamt;
            ex_pkg::OP_SRL: shift_out_o = opnd1_i >> shamt;
            // sign fill for arithmetic right shift
            ex_pkg::OP_SRA: shift_out_o = $signed(opnd1_i) >>> shamt;
            default:        shift_out_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_BEQ:  branch_taken_o = eq;
            ex_pkg::OP_BNE:  branch_taken_o = !eq;
            ex_pkg::OP_BLT:  branch_taken_o = lt_s;
            ex_pkg::OP_BGE:  branch_taken_o = !lt_s;
            ex_pkg::OP_BLTU: branch_taken_o = lt_u;
            ex_pkg::OP_BGEU: branch_taken_o = !lt_u;
            // unconditional
            ex_pkg::OP_B,
            ex_pkg::OP_JIRL: branch_taken_o = 1'b1;
            default:         branch_taken_o = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    always_comb begin
        if (aluop_i == ex_pkg::OP_JIRL) begin
            branch_target_o = opnd1_i + imm_i;
        end else begin
            branch_target_o = pc_i + imm_i;
        end
    end

endmodule

`default_nettype wire

// File: design/ex_pkg.sv
`default_nettype none

package ex_pkg;

    // datapath and field widths set by the ISA
    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int FTQ_IDW = 3;
    localparam int CSR_AW  = 14;

    typedef enum logic [5:0] {
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_B, OP_JIRL,
        OP_ADD, OP_SUB, OP_MUL, OP_MULH, OP_MULHU,
        OP_DIV, OP_DIVU, OP_MOD, OP_MODU, OP_SLT, OP_SLTU,
        OP_LUI, OP_PCADD,
        OP_CSRRD, OP_CSRWR, OP_CSRXCHG,
        OP_RDCNTVL, OP_RDCNTVH, OP_RDCNTID
    } alu_op_e;

    // which unit drives the register write data
    typedef enum logic [2:0] {
        RES_NONE, RES_LOGIC, RES_SHIFT, RES_MOVE, RES_ARITH, RES_JUMP, RES_CSR
    } res_sel_e;

    typedef enum logic [1:0] {
        SIZE_BYTE, SIZE_HALF, SIZE_WORD
    } mem_size_e;

    // micro-op from dispatch
    typedef struct packed {
        logic               valid;
        logic [XLEN-1:0]    pc;
        alu_op_e            aluop;
        res_sel_e           alusel;
        logic [XLEN-1:0]    opnd1;
        logic [XLEN-1:0]    opnd2;
        logic [XLEN-1:0]    imm;
        logic               use_imm;
        logic               wreg;
        logic [REG_AW-1:0]  waddr;
        logic               mem_load;
        logic               mem_store;
        mem_size_e          mem_size;
        logic               csr_we;
        logic [CSR_AW-1:0]  csr_addr;
        logic [XLEN-1:0]    csr_rdata;
        logic               predicted_taken;
        logic [FTQ_IDW-1:0] ftq_id;
    } ex_uop_t;

    // execute to memory pipeline register
    typedef struct packed {
        logic               valid;
        logic [XLEN-1:0]    pc;
        logic               wreg;
        logic [REG_AW-1:0]  waddr;
        logic [XLEN-1:0]    wdata;
        logic               mem_load;
        logic               mem_store;
        mem_size_e          mem_size;
        logic [XLEN-1:0]    mem_addr;
        logic [XLEN-1:0]    store_data;
        logic               csr_we;
        logic [CSR_AW-1:0]  csr_addr;
        logic [XLEN-1:0]    csr_wdata;
        logic               excp_ale;
        logic               last_in_block;
        logic [FTQ_IDW-1:0] ftq_id;
    } ex_mem_t;

    // register write forward back to dispatch
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   wdata;
    } ex_fwd_t;

endpackage

`default_nettype wire
